/* rp_sig_pkg.sv */
`default_nettype none

package rp_sig_pkg;

  ////////////////////////////////////////////////////////////
  // Sample widths
  ////////////////////////////////////////////////////////////

  localparam int ADC_W = 16;           // ADC word
  localparam int DAC_W = 14;           // DAC word
  localparam int SAT_W = 2*ADC_W + 1;  // Widest value ever saturated (error x gain)

  typedef logic        [ADC_W-1:0] adc_raw_t;   // Raw ADC, unsigned negative slope
  typedef logic signed [ADC_W-1:0] adc_smp_t;   // ADC sample, two's complement
  typedef logic signed [DAC_W-1:0] dac_smp_t;   // Signed DAC range
  typedef logic        [DAC_W-1:0] dac_code_t;  // DAC code, negative slope

  // Signed DAC limits at saturation width
  localparam logic signed [SAT_W-1:0] DAC_MAX = 2**(DAC_W-1) - 1;
  localparam logic signed [SAT_W-1:0] DAC_MIN = -(2**(DAC_W-1));

  ////////////////////////////////////////////////////////////
  // Clamp to DAC range
  ////////////////////////////////////////////////////////////

  // Narrower signed inputs arrive sign extended
  function automatic dac_smp_t sat_dac(input logic signed [SAT_W-1:0] x);
    if (x > DAC_MAX)
      return DAC_MAX[DAC_W-1:0];  // Positive rail
    else if (x < DAC_MIN)
      return DAC_MIN[DAC_W-1:0];  // Negative rail
    return x[DAC_W-1:0];
  endfunction

endpackage

`default_nettype wire

/* rp_bus_pkg.sv */
`default_nettype none

package rp_bus_pkg;

  ////////////////////////////////////////////////////////////
  // Wishbone classic
  ////////////////////////////////////////////////////////////

  localparam int WB_AW = 4;   // Word address
  localparam int WB_DW = 32;

  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] dat;  // Write data
  } wb_req_t;

  typedef struct packed {
    logic             ack;
    logic             err;  // Unmapped address
    logic [WB_DW-1:0] dat;  // Read data
  } wb_rsp_t;

  // Register map, word addresses
  localparam int unsigned REG_CTRL      = 0;
  localparam int unsigned REG_CH_BASE   = 4;  // First channel block
  localparam int unsigned REG_CH_STRIDE = 4;  // Words per channel
  localparam int unsigned OFS_GEN_LEVEL = 0;
  localparam int unsigned OFS_GEN_STEP  = 1;
  localparam int unsigned OFS_PID_SP    = 2;
  localparam int unsigned OFS_PID_KP    = 3;

  typedef struct packed {
    logic digital_loop;  // DAC feeds ADC path
  } ctrl_t;

  typedef struct packed {
    rp_sig_pkg::dac_smp_t gen_level;  // Generator offset
    rp_sig_pkg::dac_smp_t gen_step;   // Ramp increment per cycle
    rp_sig_pkg::adc_smp_t pid_sp;     // Setpoint
    logic signed [15:0]   pid_kp;     // Proportional gain
  } ch_cfg_t;

endpackage

`default_nettype wire

/* rp_adc_frontend.sv */
`timescale 1ns/100ps
`default_nettype none

module rp_adc_frontend #(
  parameter int NUM_CH = 2
)(
  input  wire                                    adc_clk,
  input  wire                                    rst_n_i,
  input  rp_sig_pkg::adc_raw_t  [NUM_CH-1:0]     adc_raw_i,   // From ADC pins
  input  rp_sig_pkg::dac_smp_t  [NUM_CH-1:0]     loop_smp_i,  // Mixer sums
  input  rp_bus_pkg::ctrl_t                      ctrl_i,
  output rp_sig_pkg::adc_smp_t  [NUM_CH-1:0]     adc_smp_o
);

  for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
    logic signed [rp_sig_pkg::DAC_W-1:0] loop_smp;
    logic signed [rp_sig_pkg::ADC_W-1:0] loop_ext;  // Sign extended loopback
    rp_sig_pkg::adc_raw_t                raw;

    assign loop_smp = loop_smp_i[i];
    assign loop_ext = loop_smp;
    assign raw      = adc_raw_i[i];

    // Negative slope to two's complement, keep MSB and flip the rest
    always_ff @(posedge adc_clk) begin
      if (!rst_n_i)
        adc_smp_o[i] <= '0;
      else if (ctrl_i.digital_loop)
        adc_smp_o[i] <= loop_ext;
      else
        adc_smp_o[i] <= {raw[rp_sig_pkg::ADC_W-1], ~raw[rp_sig_pkg::ADC_W-2:0]};
    end
  end

endmodule

`default_nettype wire

/* rp_sig_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module rp_sig_gen #(
  parameter int NUM_CH = 2
)(
  input  wire                                adc_clk,
  input  wire                                rst_n_i,
  input  rp_sig_pkg::dac_smp_t [NUM_CH-1:0]  level_i,   // DC level
  input  rp_sig_pkg::dac_smp_t [NUM_CH-1:0]  step_i,    // Ramp slope
  output rp_sig_pkg::dac_smp_t [NUM_CH-1:0]  gen_smp_o
);

  for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
    rp_sig_pkg::dac_smp_t acc_q;  // Phase accumulator

    ////////////////////////////////////////////////////////////
    // Ramp plus level, both wrap in 14 bits
    ////////////////////////////////////////////////////////////

    always_ff @(posedge adc_clk) begin
      if (!rst_n_i) begin
        acc_q        <= '0;
        gen_smp_o[i] <= '0;
      end else begin
        acc_q        <= acc_q + step_i[i];    // Free running, wraps
        gen_smp_o[i] <= level_i[i] + acc_q;   // Step 0 gives flat level
      end
    end
  end

endmodule

`default_nettype wire

/* rp_p_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module rp_p_ctrl #(
  parameter int NUM_CH   = 2,
  parameter int KP_SHIFT = 8   // Gain scaling, kp/2^KP_SHIFT
)(
  input  wire                                  adc_clk,
  input  wire                                  rst_n_i,
  input  rp_sig_pkg::adc_smp_t [NUM_CH-1:0]    adc_smp_i,  // Measured
  input  rp_sig_pkg::adc_smp_t [NUM_CH-1:0]    sp_i,       // Setpoint
  input  logic [NUM_CH-1:0][15:0]              kp_i,       // Signed gain per channel
  output rp_sig_pkg::dac_smp_t [NUM_CH-1:0]    ctl_smp_o
);

  localparam int ERR_W = rp_sig_pkg::ADC_W + 1;

  for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
    logic signed [rp_sig_pkg::ADC_W-1:0] sp;
    logic signed [rp_sig_pkg::ADC_W-1:0] smp;
    logic signed [15:0]                  kp;
    logic signed [ERR_W-1:0]             err_d;
    logic signed [ERR_W-1:0]             err_q;   // Stage one
    logic signed [rp_sig_pkg::SAT_W-1:0] prod;    // err x kp, full width
    logic signed [rp_sig_pkg::SAT_W-1:0] scaled;

    assign sp     = sp_i[i];
    assign smp    = adc_smp_i[i];
    assign kp     = kp_i[i];
    assign err_d  = sp - smp;         // 17 bits, no overflow
    assign prod   = err_q * kp;
    assign scaled = prod >>> KP_SHIFT;  // Arithmetic, keeps sign

    ////////////////////////////////////////////////////////////
    // Two register stages
    ////////////////////////////////////////////////////////////

    always_ff @(posedge adc_clk) begin
      if (!rst_n_i) begin
        err_q        <= '0;
        ctl_smp_o[i] <= '0;
      end else begin
        err_q        <= err_d;
        ctl_smp_o[i] <= rp_sig_pkg::sat_dac(scaled);  // Clamp to 14 bits
      end
    end
  end

endmodule

`default_nettype wire

/* rp_dac_mixer.sv */
`timescale 1ns/100ps
`default_nettype none

module rp_dac_mixer #(
  parameter int NUM_CH = 2
)(
  input  wire                                 adc_clk,
  input  wire                                 rst_n_i,
  input  rp_sig_pkg::dac_smp_t  [NUM_CH-1:0]  gen_smp_i,
  input  rp_sig_pkg::dac_smp_t  [NUM_CH-1:0]  ctl_smp_i,
  output rp_sig_pkg::dac_smp_t  [NUM_CH-1:0]  mix_smp_o,   // Back to ADC frontend
  output rp_sig_pkg::dac_code_t [NUM_CH-1:0]  dac_code_o
);

  localparam int W = rp_sig_pkg::DAC_W;

  for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
    logic signed [W-1:0] gen;
    logic signed [W-1:0] ctl;
    logic signed [W:0]   sum;     // One guard bit
    logic signed [W-1:0] mix_q;

    assign gen = gen_smp_i[i];
    assign ctl = ctl_smp_i[i];
    assign sum = gen + ctl;

    always_ff @(posedge adc_clk) begin
      if (!rst_n_i)
        mix_q <= '0;  // Code reads 1FFF
      else
        mix_q <= rp_sig_pkg::sat_dac(sum);
    end

    assign mix_smp_o[i]  = mix_q;
    assign dac_code_o[i] = {mix_q[W-1], ~mix_q[W-2:0]};  // Negative slope code
  end

endmodule

`default_nettype wire

/* rp_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module rp_regs #(
  parameter int NUM_CH = 2
)(
  input  wire                                  adc_clk,
  input  wire                                  rst_n_i,
  input  rp_bus_pkg::wb_req_t                  wb_i,
  output rp_bus_pkg::wb_rsp_t                  wb_o,
  output rp_bus_pkg::ctrl_t                    ctrl_o,
  output rp_bus_pkg::ch_cfg_t [NUM_CH-1:0]     ch_cfg_o
);

  localparam int DW     = rp_bus_pkg::WB_DW;
  localparam int CH_END = rp_bus_pkg::REG_CH_BASE + NUM_CH * rp_bus_pkg::REG_CH_STRIDE;

  rp_bus_pkg::ctrl_t                ctrl_q;
  rp_bus_pkg::ch_cfg_t [NUM_CH-1:0] cfg_q;
  rp_bus_pkg::wb_rsp_t              rsp_q;
  logic                             req_new;   // First cycle of a transfer
  logic                             ctrl_hit;
  logic                             ch_hit;
  int unsigned                      ch_ofs;    // Word offset inside channel area
  int unsigned                      ch_idx;
  int unsigned                      fld;
  logic [DW-1:0]                    rd_dat;

  // Read value sign extended to bus width
  function automatic logic [DW-1:0] sext(input logic signed [15:0] v);
    return {{(DW-16){v[15]}}, v};
  endfunction

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  assign req_new  = wb_i.cyc & wb_i.stb & ~rsp_q.ack & ~rsp_q.err;  // Gap after each pulse
  assign ctrl_hit = (wb_i.adr == rp_bus_pkg::REG_CTRL);
  assign ch_hit   = (wb_i.adr >= rp_bus_pkg::REG_CH_BASE) && (wb_i.adr < CH_END);
  assign ch_ofs   = wb_i.adr - rp_bus_pkg::REG_CH_BASE;
  assign ch_idx   = ch_ofs / rp_bus_pkg::REG_CH_STRIDE;
  assign fld      = ch_ofs % rp_bus_pkg::REG_CH_STRIDE;

  always_comb begin
    rd_dat = '0;  // Also the data returned with err
    if (ctrl_hit) begin
      rd_dat[0] = ctrl_q.digital_loop;
    end else if (ch_hit) begin
      case (fld)
        rp_bus_pkg::OFS_GEN_LEVEL: rd_dat = sext(cfg_q[ch_idx].gen_level);
        rp_bus_pkg::OFS_GEN_STEP:  rd_dat = sext(cfg_q[ch_idx].gen_step);
        rp_bus_pkg::OFS_PID_SP:    rd_dat = sext(cfg_q[ch_idx].pid_sp);
        default:                   rd_dat = sext(cfg_q[ch_idx].pid_kp);
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Registers and response
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      ctrl_q <= '0;
      cfg_q  <= '0;
      rsp_q  <= '0;
    end else begin
      rsp_q.ack <= req_new & (ctrl_hit | ch_hit);
      rsp_q.err <= req_new & ~(ctrl_hit | ch_hit);  // Unmapped, nothing written
      rsp_q.dat <= rd_dat;
      if (req_new && wb_i.we && ctrl_hit)
        ctrl_q.digital_loop <= wb_i.dat[0];
      if (req_new && wb_i.we && ch_hit) begin
        case (fld)  // Low bits of the bus word
          rp_bus_pkg::OFS_GEN_LEVEL:
            cfg_q[ch_idx].gen_level <= wb_i.dat[rp_sig_pkg::DAC_W-1:0];
          rp_bus_pkg::OFS_GEN_STEP:
            cfg_q[ch_idx].gen_step  <= wb_i.dat[rp_sig_pkg::DAC_W-1:0];
          rp_bus_pkg::OFS_PID_SP:
            cfg_q[ch_idx].pid_sp    <= wb_i.dat[rp_sig_pkg::ADC_W-1:0];
          default:
            cfg_q[ch_idx].pid_kp    <= wb_i.dat[15:0];
        endcase
      end
    end
  end

  assign wb_o     = rsp_q;
  assign ctrl_o   = ctrl_q;
  assign ch_cfg_o = cfg_q;

endmodule

`default_nettype wire

/* rp_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rp_top #(
  parameter int NUM_CH   = 2,
  parameter int KP_SHIFT = 8
)(
  input  wire                                  adc_clk,
  input  wire                                  rst_n_i,   // Synchronous
  input  rp_sig_pkg::adc_raw_t  [NUM_CH-1:0]   adc_dat_i,
  output rp_sig_pkg::dac_code_t [NUM_CH-1:0]   dac_dat_o,
  input  rp_bus_pkg::wb_req_t                  wb_i,
  output rp_bus_pkg::wb_rsp_t                  wb_o
);

  rp_bus_pkg::ctrl_t                 ctrl;
  rp_bus_pkg::ch_cfg_t  [NUM_CH-1:0] ch_cfg;
  rp_sig_pkg::dac_smp_t [NUM_CH-1:0] gen_level;
  rp_sig_pkg::dac_smp_t [NUM_CH-1:0] gen_step;
  rp_sig_pkg::adc_smp_t [NUM_CH-1:0] pid_sp;
  logic [NUM_CH-1:0][15:0]           pid_kp;
  rp_sig_pkg::adc_smp_t [NUM_CH-1:0] adc_smp;   // Two's complement ADC
  rp_sig_pkg::dac_smp_t [NUM_CH-1:0] gen_smp;   // Generator out
  rp_sig_pkg::dac_smp_t [NUM_CH-1:0] ctl_smp;   // Controller out
  rp_sig_pkg::dac_smp_t [NUM_CH-1:0] mix_smp;   // Loopback source

  // Split channel config into per-block arrays
  for (genvar i = 0; i < NUM_CH; i++) begin : g_cfg
    assign gen_level[i] = ch_cfg[i].gen_level;
    assign gen_step[i]  = ch_cfg[i].gen_step;
    assign pid_sp[i]    = ch_cfg[i].pid_sp;
    assign pid_kp[i]    = ch_cfg[i].pid_kp;
  end

  ////////////////////////////////////////////////////////////
  // Register block and signal path
  ////////////////////////////////////////////////////////////

  rp_regs #(.NUM_CH(NUM_CH)) rp_regs_inst (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .wb_i    (wb_i),    .wb_o    (wb_o),
    .ctrl_o  (ctrl),    .ch_cfg_o (ch_cfg)
  );

  rp_adc_frontend #(.NUM_CH(NUM_CH)) rp_adc_frontend_inst (
    .adc_clk   (adc_clk),   .rst_n_i    (rst_n_i),
    .adc_raw_i (adc_dat_i), .loop_smp_i (mix_smp),
    .ctrl_i    (ctrl),      .adc_smp_o  (adc_smp)
  );

  rp_sig_gen #(.NUM_CH(NUM_CH)) rp_sig_gen_inst (
    .adc_clk (adc_clk),   .rst_n_i (rst_n_i),
    .level_i (gen_level), .step_i  (gen_step),
    .gen_smp_o (gen_smp)
  );

  rp_p_ctrl #(.NUM_CH(NUM_CH), .KP_SHIFT(KP_SHIFT)) rp_p_ctrl_inst (
    .adc_clk   (adc_clk), .rst_n_i (rst_n_i),
    .adc_smp_i (adc_smp), .sp_i    (pid_sp),
    .kp_i      (pid_kp),  .ctl_smp_o (ctl_smp)
  );

  rp_dac_mixer #(.NUM_CH(NUM_CH)) rp_dac_mixer_inst (
    .adc_clk   (adc_clk), .rst_n_i   (rst_n_i),
    .gen_smp_i (gen_smp), .ctl_smp_i (ctl_smp),
    .mix_smp_o (mix_smp), .dac_code_o (dac_dat_o)
  );

endmodule

`default_nettype wire

/* tb_rp_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rp_top;

  localparam int NUM_CH   = 2;
  localparam int KP_SHIFT = 8;
  localparam int WAIT_MAX = 64;  // Cycles before any wait gives up

  // One table row, per-channel settings and expected DAC codes
  typedef struct {
    string                              name;
    logic                               loop;
    rp_sig_pkg::dac_smp_t  [NUM_CH-1:0] level;
    rp_sig_pkg::adc_smp_t  [NUM_CH-1:0] sp;
    logic [NUM_CH-1:0][15:0]            kp;
    rp_sig_pkg::adc_raw_t  [NUM_CH-1:0] raw;
    rp_sig_pkg::dac_code_t [NUM_CH-1:0] exp_code;
  } entry_t;

  logic                               adc_clk;
  logic                               rst_n_i;
  rp_sig_pkg::adc_raw_t  [NUM_CH-1:0] adc_dat_i;
  rp_sig_pkg::dac_code_t [NUM_CH-1:0] dac_dat_o;
  rp_bus_pkg::wb_req_t                wb_i;
  rp_bus_pkg::wb_rsp_t                wb_o;
  entry_t                             tbl[$];
  int                                 seed = 79;  // Filler ADC words

  rp_top #(.NUM_CH(NUM_CH), .KP_SHIFT(KP_SHIFT)) rp_top_inst (
    .adc_clk (adc_clk),   .rst_n_i   (rst_n_i),
    .adc_dat_i (adc_dat_i), .dac_dat_o (dac_dat_o),
    .wb_i    (wb_i),      .wb_o      (wb_o)
  );

  initial adc_clk = 1'b0;
  always #10 adc_clk = ~adc_clk;  // 20 ns period

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic rp_sig_pkg::adc_smp_t adc_conv(input rp_sig_pkg::adc_raw_t r);
    return r ^ 16'h7FFF;  // MSB stays, rest flipped
  endfunction

  function automatic rp_sig_pkg::dac_code_t dac_conv(input rp_sig_pkg::dac_smp_t v);
    return v ^ 14'h1FFF;
  endfunction

  function automatic longint clamp14(input longint x);
    if (x > 8191)
      return 8191;
    if (x < -8192)
      return -8192;
    return x;
  endfunction

  function automatic rp_sig_pkg::dac_code_t model_code(input rp_sig_pkg::dac_smp_t lvl,
      input rp_sig_pkg::adc_smp_t sp, input logic signed [15:0] kp,
      input rp_sig_pkg::adc_raw_t raw);
    longint err;
    longint ctl;
    longint mix;
    err = longint'(sp) - longint'(adc_conv(raw));
    ctl = clamp14((err * longint'(kp)) >>> KP_SHIFT);  // Floor, like an arithmetic shift
    mix = clamp14(longint'(lvl) + ctl);
    return dac_conv(rp_sig_pkg::dac_smp_t'(mix));
  endfunction

  function automatic logic [31:0] sign_ext(input logic [31:0] v, input int w);
    logic signed [31:0] t;
    t = v << (32 - w);
    return t >>> (32 - w);
  endfunction

  function automatic int unsigned ch_adr(input int ch, input int unsigned ofs);
    return rp_bus_pkg::REG_CH_BASE + ch * rp_bus_pkg::REG_CH_STRIDE + ofs;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks and bus access
  ////////////////////////////////////////////////////////////

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic tick();
    @(posedge adc_clk);
    #2;  // Drive and sample point
  endtask

  task automatic check_code(input string name, input rp_sig_pkg::dac_code_t exp_v,
                            input rp_sig_pkg::dac_code_t act_v);
    if (act_v !== exp_v)
      stop_run($sformatf("mismatch %s: expected %h, actual %h", name, exp_v, act_v));
  endtask

  task automatic check_word(input string name, input logic [rp_bus_pkg::WB_DW-1:0] exp_v,
                            input logic [rp_bus_pkg::WB_DW-1:0] act_v);
    if (act_v !== exp_v)
      stop_run($sformatf("mismatch %s: expected %h, actual %h", name, exp_v, act_v));
  endtask

  task automatic check_resp(input string name, input logic exp_err,
                            input rp_bus_pkg::wb_rsp_t rsp);
    if (rsp.err !== exp_err || rsp.ack !== !exp_err)
      stop_run($sformatf("mismatch %s: expected %s, actual ack=%b err=%b",
                         name, exp_err ? "err" : "ack", rsp.ack, rsp.err));
  endtask

  task automatic bus_xfer(input string name, input logic we, input int unsigned adr,
                          input logic [31:0] wdat, input logic exp_err,
                          output logic [31:0] rdat);
    int n;
    wb_i     = '0;
    wb_i.cyc = 1'b1;
    wb_i.stb = 1'b1;
    wb_i.we  = we;
    wb_i.adr = adr[rp_bus_pkg::WB_AW-1:0];
    wb_i.dat = wdat;  // Held until ack or err
    n = 0;
    do begin
      tick();
      n++;
      if (n > WAIT_MAX)
        stop_run($sformatf("%s: no Wishbone response at address %0d", name, adr));
    end while (!(wb_o.ack || wb_o.err));
    check_resp(name, exp_err, wb_o);
    rdat = wb_o.dat;
    wb_i = '0;
    tick();
    if (wb_o.ack || wb_o.err)  // Pulse must be one cycle
      stop_run($sformatf("%s: Wishbone response held longer than one cycle", name));
  endtask

  task automatic wb_write(input string name, input int unsigned adr, input logic [31:0] dat);
    logic [31:0] rd_dummy;
    bus_xfer(name, 1'b1, adr, dat, 1'b0, rd_dummy);
  endtask

  task automatic wb_read(input string name, input int unsigned adr, input logic [31:0] exp_v);
    logic [31:0] rdat;
    bus_xfer(name, 1'b0, adr, 32'h0, 1'b0, rdat);
    check_word(name, exp_v, rdat);
  endtask

  ////////////////////////////////////////////////////////////
  // Table
  ////////////////////////////////////////////////////////////

  // Raw word below zero means random filler
  task automatic add_entry(input string name, input logic loop, input int l0, input int l1,
                           input int sp0, input int sp1, input int kp0, input int kp1,
                           input int r0, input int r1);
    entry_t e;
    int     lv[NUM_CH];
    int     spv[NUM_CH];
    int     kpv[NUM_CH];
    int     rv[NUM_CH];
    lv  = '{l0, l1};
    spv = '{sp0, sp1};
    kpv = '{kp0, kp1};
    rv  = '{r0, r1};
    e.name = name;
    e.loop = loop;
    for (int c = 0; c < NUM_CH; c++) begin
      e.level[c] = rp_sig_pkg::dac_smp_t'(lv[c]);
      e.sp[c]    = rp_sig_pkg::adc_smp_t'(spv[c]);
      e.kp[c]    = 16'(kpv[c]);
      e.raw[c]   = (rv[c] < 0) ? rp_sig_pkg::adc_raw_t'($random(seed))
                               : rp_sig_pkg::adc_raw_t'(rv[c]);
      // Loop with sp = level settles on the level itself
      e.exp_code[c] = loop ? dac_conv(e.level[c])
                           : model_code(e.level[c], e.sp[c], e.kp[c], e.raw[c]);
    end
    tbl.push_back(e);
  endtask

  task automatic apply_entry(input entry_t e);
    int n;
    for (int c = 0; c < NUM_CH; c++) begin
      wb_write(e.name, ch_adr(c, rp_bus_pkg::OFS_GEN_LEVEL), 32'(e.level[c]));
      wb_write(e.name, ch_adr(c, rp_bus_pkg::OFS_GEN_STEP), 32'h0);  // Flat generator
      wb_write(e.name, ch_adr(c, rp_bus_pkg::OFS_PID_SP), 32'(e.sp[c]));
      wb_write(e.name, ch_adr(c, rp_bus_pkg::OFS_PID_KP), 32'(e.kp[c]));
    end
    wb_write(e.name, rp_bus_pkg::REG_CTRL, 32'(e.loop));
    adc_dat_i = e.raw;
    n = 0;
    do begin  // At least 8 cycles, then until settled
      tick();
      n++;
      if (n > WAIT_MAX) begin
        for (int c = 0; c < NUM_CH; c++)
          check_code(e.name, e.exp_code[c], dac_dat_o[c]);
      end
    end while (n < 8 || dac_dat_o !== e.exp_code);
    for (int k = 0; k < 6; k++) begin  // Must hold steady
      if (e.loop)
        adc_dat_i = $random(seed);  // Ignored while looped
      tick();
      for (int c = 0; c < NUM_CH; c++)
        check_code(e.name, e.exp_code[c], dac_dat_o[c]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rp_sig_pkg::dac_smp_t  [NUM_CH-1:0] ramp_step;
    rp_sig_pkg::dac_code_t [NUM_CH-1:0] prev;
    logic [31:0]                        val;
    logic [31:0]                        rd_dummy;
    int                                 w;
    rst_n_i   = 1'b0;
    wb_i      = '0;
    adc_dat_i = $random(seed);
    repeat (5) @(posedge adc_clk);
    #2;
    rst_n_i = 1'b1;
    for (int k = 0; k < 4; k++) begin  // Mid scale code, bus idle
      for (int c = 0; c < NUM_CH; c++)
        check_code("reset", 14'h1FFF, dac_dat_o[c]);
      if (wb_o.ack || wb_o.err)
        stop_run("Wishbone response active after reset");
      tick();
    end

    // Generator steps stay zero until the ramp test
    add_entry("const_level", 0, 256, -256, 0, 0, 0, 0, -1, -1);
    add_entry("p_mid", 0, 0, 100, 1024, -500, 256, -128, 'h7FFF, 'h8000);
    add_entry("p_sat_inner", 0, 1000, -100, 32767, -32768, 32767, 32767, 'hFFFF, 'h0000);
    add_entry("p_sat_outer", 0, 8000, -8000, 2000, -2000, 256, 256, 'h7FFF, 'h7FFF);
    add_entry("loop_on", 1, 1234, -3000, 1234, -3000, 64, 64, -1, -1);
    add_entry("loop_off", 0, -50, 700, 300, -1200, 512, -96, 'h1234, 'hABCD);
    foreach (tbl[i])
      apply_entry(tbl[i]);

    // Register readback, sign extended
    wb_write("ctrl", rp_bus_pkg::REG_CTRL, 32'h1);
    wb_read("ctrl", rp_bus_pkg::REG_CTRL, 32'h1);
    for (int c = 0; c < NUM_CH; c++) begin
      for (int unsigned f = 0; f < rp_bus_pkg::REG_CH_STRIDE; f++) begin
        val = $random(seed);
        w   = (f == rp_bus_pkg::OFS_GEN_LEVEL || f == rp_bus_pkg::OFS_GEN_STEP) ?
              rp_sig_pkg::DAC_W : rp_sig_pkg::ADC_W;
        wb_write($sformatf("reg_ch%0d_%0d", c, f), ch_adr(c, f), val);
        wb_read($sformatf("reg_ch%0d_%0d", c, f), ch_adr(c, f), sign_ext(val, w));
      end
    end
    bus_xfer("unmapped_3", 1'b1, 3, 32'h0, 1'b1, rd_dummy);
    bus_xfer("unmapped_15", 1'b1, 15, 32'h0, 1'b1, rd_dummy);
    wb_read("ctrl_after_err", rp_bus_pkg::REG_CTRL, 32'h1);  // Untouched by err
    wb_write("ctrl", rp_bus_pkg::REG_CTRL, 32'h0);

    // Ramp, one step per cycle, wraps in 14 bits
    ramp_step = {14'sh3F00, 14'sh0123};  // ch1 falls, ch0 rises
    for (int c = 0; c < NUM_CH; c++) begin
      wb_write("ramp", ch_adr(c, rp_bus_pkg::OFS_GEN_LEVEL), 32'h5 + c);
      wb_write("ramp", ch_adr(c, rp_bus_pkg::OFS_PID_KP), 32'h0);
      wb_write("ramp", ch_adr(c, rp_bus_pkg::OFS_GEN_STEP), 32'(ramp_step[c]));
    end
    repeat (8) tick();
    prev = dac_dat_o;
    for (int k = 0; k < 16; k++) begin
      tick();
      for (int c = 0; c < NUM_CH; c++)
        check_code("ramp", dac_conv(dac_conv(prev[c]) + ramp_step[c]), dac_dat_o[c]);
      prev = dac_dat_o;
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
rp_sig_pkg.sv
rp_bus_pkg.sv
rp_adc_frontend.sv
rp_sig_gen.sv
rp_p_ctrl.sv
rp_dac_mixer.sv
rp_regs.sv
rp_top.sv
tb_rp_top.sv
